// File: obj_pkg.sv
// Shared definitions for the object (sprite) path.
// Holds table widths, the entry layout and the pixel and coordinate types.
// Modules take what they need by a wildcard import in their header.

`default_nettype none

package obj_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Object table layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OBJ_WORDS  = 4;             // Words per entry.
    localparam int WORD_X     = 0;             // Horizontal position.
    localparam int WORD_Y     = 1;             // Vertical position.
    // Word 2 holds the tile code. It is stored but not read by the scanner.
    localparam int WORD_ATTR  = 3;             // Attributes, colour in the low byte.

    localparam int ATTR_END_BIT = 15;          // Set on the entry that ends the table.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and pixel widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W     = 13;            // CPU word address, top bit picks the bank.
    localparam int GFX_ADDR_W = 12;            // Word address inside one bank.
    localparam int POS_W      = 9;             // Screen coordinates wrap at 512.
    localparam int PIX_W      = 8;             // Pixel value. Zero is transparent.
    localparam int OBJ_SIZE   = 16;            // Objects are square blocks.

    typedef logic [15:0]      obj_word_t;      // One table word.
    typedef logic [PIX_W-1:0] pix_t;           // One pixel.
    typedef logic [POS_W-1:0] pos_t;           // X, Y, line or column.

endpackage

`default_nettype wire

// File: obj_ram.sv
// Double-banked object table.
// The CPU reads and writes 16-bit words with byte enables in the bank it
// sees, while the graphics side reads the other bank for the frame on show.
// Flipping obank swaps the two banks between the CPU and the scanner.

`timescale 1ns/1ps
`default_nettype none

module obj_ram import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  obank,       // Bank select, flipped once per frame.

    // CPU port.
    input  logic                  cs,
    output logic                  ok,
    input  logic [1:0]            dsn,         // Active low byte enables.
    input  obj_word_t             main_dout,
    input  logic                  main_rnw,
    input  logic [ADDR_W-1:0]     main_addr,
    output obj_word_t             dout2cpu,

    // Scanner port.
    input  logic [GFX_ADDR_W-1:0] obj_addr,
    output obj_word_t             gfx_data
);

    logic [ADDR_W-1:0] cpu_addr;               // CPU address after the bank swap.
    logic [ADDR_W-1:0] gfx_addr;               // Always points into the hidden bank.
    logic              cpu_wr;

    assign cpu_addr = {main_addr[ADDR_W-1] ^ obank, main_addr[GFX_ADDR_W-1:0]};
    assign gfx_addr = {~obank, obj_addr};
    assign cpu_wr   = cs & ~main_rnw;          // Reads never touch the table.

    // Acknowledge one cycle after select, when read data is out.
    always_ff @(posedge clk) begin
        if (reset) begin
            ok <= 1'b0;
        end else begin
            ok <= cs;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One byte-wide dual-port array per lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar lane = 0; lane < 2; lane++) begin : g_lane
        logic [7:0] mem [0:(1 << ADDR_W) - 1];   // Both banks of this lane.
        logic [7:0] cpu_q;
        logic [7:0] gfx_q;

        // CPU side. Read returns the old byte on a write cycle.
        always_ff @(posedge clk) begin
            if (cpu_wr && !dsn[lane]) begin
                mem[cpu_addr] <= main_dout[lane*8 +: 8];
            end
            cpu_q <= mem[cpu_addr];
        end

        // Graphics side, read only.
        always_ff @(posedge clk) begin
            gfx_q <= mem[gfx_addr];
        end

        assign dout2cpu[lane*8 +: 8] = cpu_q;
        assign gfx_data[lane*8 +: 8] = gfx_q;
    end

endmodule

`default_nettype wire

// File: obj_scan.sv
// Object table scanner.
// On each line_start it waits for the line buffer to clear, then walks the
// shown bank entry by entry and issues a draw strobe for every object that
// covers the line. line_done pulses once the last span is painted.
// The scan stops after OBJ_COUNT entries or at an entry with the end bit set.
// The end-marker entry itself is not drawn.

`timescale 1ns/1ps
`default_nettype none

module obj_scan import obj_pkg::*; #(
    parameter int OBJ_COUNT = 256              // Entries scanned at most, up to 1024.
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start,
    input  pos_t                  vpos,
    input  obj_word_t             gfx_data,    // Arrives one cycle after obj_addr.
    input  logic                  busy,        // Line buffer clearing or painting.
    output logic [GFX_ADDR_W-1:0] obj_addr,
    output logic                  draw,
    output pos_t                  draw_x,
    output pix_t                  draw_pix,
    output logic                  line_done
);

    localparam int WSEL_W = $clog2(OBJ_WORDS);
    localparam int IDX_W  = GFX_ADDR_W - WSEL_W;

    typedef enum logic [2:0] {
        S_IDLE,                                // Waiting for a line.
        S_CLEAR,                               // Line buffer still clearing.
        S_FETCH,                               // Reading X, Y and attributes.
        S_EVAL,                                // Attribute word on gfx_data.
        S_DRAW,                                // Hit waiting for the buffer.
        S_FINISH                               // Last span still painting.
    } state_t;

    state_t            state;
    logic [IDX_W-1:0]  idx;                    // Current entry.
    logic [WSEL_W-1:0] wsel;                   // Word being requested.
    pos_t              line_q;                 // Line being rendered.
    pos_t              x_q;
    pos_t              y_q;
    pos_t              dy;                     // Row inside the object, mod 512.
    logic              hit;
    logic              last;

    assign obj_addr = {idx, wsel};
    assign dy       = line_q - y_q;
    assign hit      = (dy < POS_W'(OBJ_SIZE)) && (gfx_data[PIX_W-1:0] != '0);
    assign last     = (idx == IDX_W'(OBJ_COUNT - 1));

    always_ff @(posedge clk) begin
        draw      <= 1'b0;                     // Both are one-cycle pulses.
        line_done <= 1'b0;
        if (reset) begin
            state <= S_IDLE;
            idx   <= '0;
            wsel  <= '0;
        end else if (line_start) begin
            state  <= S_CLEAR;                 // Restart from the first entry.
            idx    <= '0;
            wsel   <= WSEL_W'(WORD_X);
            line_q <= vpos;
        end else begin
            case (state)
                S_CLEAR: begin
                    if (!busy) begin
                        state <= S_FETCH;
                    end
                end
                // Each cycle requests one word and captures the one before.
                S_FETCH: begin
                    case (wsel)
                        WSEL_W'(WORD_X): begin
                            wsel <= WSEL_W'(WORD_Y);
                        end
                        WSEL_W'(WORD_Y): begin
                            x_q  <= gfx_data[POS_W-1:0];   // X arrives.
                            wsel <= WSEL_W'(WORD_ATTR);
                        end
                        default: begin
                            y_q   <= gfx_data[POS_W-1:0];  // Y arrives.
                            state <= S_EVAL;
                        end
                    endcase
                end
                S_EVAL: begin
                    if (gfx_data[ATTR_END_BIT]) begin
                        state <= S_FINISH;
                    end else if (hit) begin
                        draw_x   <= x_q;
                        draw_pix <= gfx_data[PIX_W-1:0];
                        state    <= S_DRAW;
                    end else if (last) begin
                        state <= S_FINISH;
                    end else begin
                        idx   <= idx + 1'b1;
                        wsel  <= WSEL_W'(WORD_X);
                        state <= S_FETCH;
                    end
                end
                S_DRAW: begin
                    if (!busy) begin
                        draw <= 1'b1;
                        if (last) begin
                            state <= S_FINISH;
                        end else begin
                            idx   <= idx + 1'b1;
                            wsel  <= WSEL_W'(WORD_X);
                            state <= S_FETCH;
                        end
                    end
                end
                S_FINISH: begin
                    // busy rises the cycle after draw, so skip that cycle.
                    if (!busy && !draw) begin
                        line_done <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: obj_line_buf.sv
// Ping-pong object line buffer.
// One half is shown while the other is drawn. line_start swaps the halves
// and clears the new draw half, one pixel per cycle. Each draw strobe then
// paints a 16-pixel span, leaving pixels that are already set untouched,
// so earlier table entries stay on top. busy covers clearing and painting.

`timescale 1ns/1ps
`default_nettype none

module obj_line_buf import obj_pkg::*; #(
    parameter int LINE_W = 384                 // Visible pixels, up to 512.
) (
    input  logic clk,
    input  logic reset,
    input  logic line_start,
    input  logic draw,
    input  pos_t draw_x,
    input  pix_t draw_pix,
    input  pos_t pix_x,                        // Display column.
    output logic busy,
    output pix_t pix
);

    localparam int CNT_W = $clog2(OBJ_SIZE);

    pix_t             line_mem [2][LINE_W];    // Both halves.
    logic             disp_half;               // Half on display.
    logic             clearing;
    logic             painting;
    logic [POS_W-1:0] clr_addr;
    logic [POS_W:0]   paint_addr;              // One extra bit for spans past 511.
    logic [CNT_W-1:0] paint_cnt;
    pix_t             paint_pix;
    logic             paint_in;                // Span pixel lies on the line.
    pix_t             paint_old;               // Pixel already at paint_addr.

    assign busy      = clearing | painting;
    assign paint_in  = paint_addr < LINE_W;
    assign paint_old = paint_in ? line_mem[~disp_half][paint_addr[POS_W-1:0]] : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clear and paint control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            disp_half <= 1'b0;
            clearing  <= 1'b0;
            painting  <= 1'b0;
        end else if (line_start) begin
            disp_half <= ~disp_half;           // Drawn half goes on show.
            clearing  <= 1'b1;
            clr_addr  <= '0;
            painting  <= 1'b0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == POS_W'(LINE_W - 1)) begin
                clearing <= 1'b0;              // LINE_W cycles in all.
            end
        end else if (painting) begin
            paint_addr <= paint_addr + 1'b1;
            paint_cnt  <= paint_cnt + 1'b1;
            if (paint_cnt == CNT_W'(OBJ_SIZE - 1)) begin
                painting <= 1'b0;              // Span finished.
            end
        end else if (draw) begin
            painting   <= 1'b1;
            paint_addr <= {1'b0, draw_x};
            paint_cnt  <= '0;
            paint_pix  <= draw_pix;
        end
    end

    // Writes into the draw half. Set pixels win over later objects.
    always_ff @(posedge clk) begin
        if (clearing) begin
            line_mem[~disp_half][clr_addr] <= '0;
        end else if (painting && !line_start && paint_in && paint_old == '0) begin
            line_mem[~disp_half][paint_addr[POS_W-1:0]] <= paint_pix;
        end
    end

    // Display read, one cycle behind pix_x.
    always_ff @(posedge clk) begin
        if (reset) begin
            pix <= '0;
        end else if (pix_x < LINE_W) begin
            pix <= line_mem[disp_half][pix_x];
        end else begin
            pix <= '0;                         // Off the line is transparent.
        end
    end

endmodule

`default_nettype wire

// File: obj_top.sv
// Object path top level.
// Three stages in a row: table fetch, hit detection and span painting.
// The CPU fills one bank of the table while the scanner reads the other,
// and the line buffer serves the finished line as display pixels.
// OBJ_COUNT and LINE_W are set here and passed down.

`timescale 1ns/1ps
`default_nettype none

module obj_top import obj_pkg::*; #(
    parameter int OBJ_COUNT = 256,             // Entries scanned per line.
    parameter int LINE_W    = 384              // Visible pixels per line.
) (
    input  logic              clk,
    input  logic              reset,

    // CPU side.
    input  logic              obank,
    input  logic              cs,
    output logic              ok,
    input  logic [1:0]        dsn,
    input  obj_word_t         main_dout,
    input  logic              main_rnw,
    input  logic [ADDR_W-1:0] main_addr,
    output obj_word_t         dout2cpu,

    // Line control and display.
    input  logic              line_start,
    input  pos_t              vpos,
    output logic              line_done,
    input  pos_t              pix_x,
    output pix_t              pix
);

    logic [GFX_ADDR_W-1:0] obj_addr;           // Scanner into the table.
    obj_word_t             gfx_data;
    logic                  draw;               // Scanner into the line buffer.
    pos_t                  draw_x;
    pix_t                  draw_pix;
    logic                  busy;               // Back-pressure to the scanner.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    obj_ram u_ram (
        .clk       (clk),
        .reset     (reset),
        .obank     (obank),
        .cs        (cs),
        .ok        (ok),
        .dsn       (dsn),
        .main_dout (main_dout),
        .main_rnw  (main_rnw),
        .main_addr (main_addr),
        .dout2cpu  (dout2cpu),
        .obj_addr  (obj_addr),
        .gfx_data  (gfx_data)
    );

    obj_scan #(
        .OBJ_COUNT (OBJ_COUNT)
    ) u_scan (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .vpos       (vpos),
        .gfx_data   (gfx_data),
        .busy       (busy),
        .obj_addr   (obj_addr),
        .draw       (draw),
        .draw_x     (draw_x),
        .draw_pix   (draw_pix),
        .line_done  (line_done)
    );

    obj_line_buf #(
        .LINE_W (LINE_W)
    ) u_line_buf (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .draw       (draw),
        .draw_x     (draw_x),
        .draw_pix   (draw_pix),
        .pix_x      (pix_x),
        .busy       (busy),
        .pix        (pix)
    );

endmodule

`default_nettype wire

// File: obj_chk.sv
// Concurrent checks on the object path, bound into obj_top.
// Covers the CPU acknowledge, scanner back-pressure and line sequencing.

`timescale 1ns/1ps
`default_nettype none

module obj_chk (
    input logic clk,
    input logic reset,
    input logic cs,
    input logic ok,
    input logic draw,
    input logic busy,
    input logic line_start,
    input logic line_done
);

    logic rendering;                                    // Between line_start and line_done.
    int   fail_count = 0;                               // Failed assertions so far.

    always_ff @(posedge clk) begin
        if (reset) begin
            rendering <= 1'b0;
        end else if (line_start) begin
            rendering <= 1'b1;
        end else if (line_done) begin
            rendering <= 1'b0;
        end
    end

    ok_follows_cs: assert property (@(posedge clk) disable iff (reset) ok == $past(cs))
        else begin
            $error("ok is not cs delayed by one cycle");
            fail_count++;
        end

    no_draw_busy: assert property (@(posedge clk) disable iff (reset) draw |-> !busy)
        else begin
            $error("draw strobe while the line buffer is busy");
            fail_count++;
        end

    one_line_at_a_time: assert property (@(posedge clk) disable iff (reset)
        line_start |-> !rendering)
        else begin
            $error("line_start before line_done of the previous line");
            fail_count++;
        end

endmodule

bind obj_top obj_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .cs         (cs),
    .ok         (ok),
    .draw       (draw),
    .busy       (busy),
    .line_start (line_start),
    .line_done  (line_done)
);

`default_nettype wire

// File: obj_tb.sv
// Testbench for the object path.
// Replays obj_testdata.txt, which holds CPU writes and reads, bank flips,
// line renders and pixel checks. Inputs change on the falling clock edge
// and outputs are sampled there too. One line per test, then the totals.

`timescale 1ns/1ps
`default_nettype none

module obj_tb import obj_pkg::*; ();

    localparam int OBJ_COUNT   = 256;
    localparam int LINE_W      = 384;
    localparam int STEP_CYCLES = LINE_W + OBJ_COUNT * OBJ_WORDS + 64;   // Worst step.

    logic              clk;
    logic              reset;
    logic              obank;
    logic              cs;
    logic              ok;
    logic [1:0]        dsn;
    obj_word_t         main_dout;
    logic              main_rnw;
    logic [ADDR_W-1:0] main_addr;
    obj_word_t         dout2cpu;
    logic              line_start;
    pos_t              vpos;
    logic              line_done;
    pos_t              pix_x;
    pix_t              pix;

    integer            fd;
    integer            code;
    int                n_cmd     = 0;
    int                limit     = 0;                   // Zero until the script is counted.
    int                cycles    = 0;
    int                test_err  = 0;
    int                total_err = 0;
    int                n_tests   = 0;
    int                n_failed  = 0;
    logic [8*32-1:0]   test_name;
    logic [8*128-1:0]  rest;                            // Remainder of a script line.
    logic [7:0]        cmd;
    logic [31:0]       a_arg;
    logic [31:0]       b_arg;
    logic [31:0]       c_arg;

    obj_top #(
        .OBJ_COUNT (OBJ_COUNT),
        .LINE_W    (LINE_W)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .obank      (obank),
        .cs         (cs),
        .ok         (ok),
        .dsn        (dsn),
        .main_dout  (main_dout),
        .main_rnw   (main_rnw),
        .main_addr  (main_addr),
        .dout2cpu   (dout2cpu),
        .line_start (line_start),
        .vpos       (vpos),
        .line_done  (line_done),
        .pix_x      (pix_x),
        .pix        (pix)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                               // 10 ns period.

    // Watchdog on the whole run.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and line tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic cpu_write(input logic [ADDR_W-1:0] addr, input obj_word_t data,
                             input logic [1:0] be_n);
        @(negedge clk);
        cs        = 1'b1;
        main_rnw  = 1'b0;                               // Write cycle.
        main_addr = addr;
        main_dout = data;
        dsn       = be_n;
        @(negedge clk);
        cs       = 1'b0;
        main_rnw = 1'b1;
        dsn      = 2'b11;
    endtask

    task automatic cpu_read(input logic [ADDR_W-1:0] addr, input obj_word_t exp);
        @(negedge clk);
        cs        = 1'b1;
        main_rnw  = 1'b1;
        main_addr = addr;
        @(negedge clk);
        cs = 1'b0;                                      // Data is out one cycle after cs.
        assert (dout2cpu === exp) else begin
            $display("ERR %0s read %h: expected %h, actual %h", test_name, addr, exp, dout2cpu);
            test_err++;
        end
    endtask

    // One line_start pulse, then wait for the scan it starts to end.
    task automatic start_line(input pos_t line);
        @(negedge clk);
        line_start = 1'b1;
        vpos       = line;
        @(negedge clk);
        line_start = 1'b0;
        while (!line_done) begin
            @(negedge clk);
        end
    endtask

    // Draw the line, then swap it onto the display half.
    task automatic render_line(input pos_t line);
        start_line(line);
        start_line(line);
    endtask

    task automatic check_pixel(input pos_t x, input pix_t exp);
        @(negedge clk);
        pix_x = x;
        @(negedge clk);                                 // pix is registered.
        assert (pix === exp) else begin
            $display("ERR %0s pixel %h: expected %h, actual %h", test_name, x, exp, pix);
            test_err++;
        end
    endtask

    task automatic close_test();
        if (test_name != '0) begin
            n_tests++;
            if (test_err == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                $display("test %0s: %0d errors", test_name, test_err);
                n_failed++;
            end
        end
        total_err += test_err;
        test_err = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Script replay
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        reset      = 1'b1;
        obank      = 1'b0;
        cs         = 1'b0;
        dsn        = 2'b11;
        main_dout  = '0;
        main_rnw   = 1'b1;
        main_addr  = '0;
        line_start = 1'b0;
        vpos       = '0;
        pix_x      = '0;
        test_name  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("obj_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open obj_testdata.txt");
            total_err++;
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin  // First pass counts commands.
                if (cmd != "#") begin
                    n_cmd++;
                end
                code = $fgets(rest, fd);
            end
            $fclose(fd);
            limit = cycles + n_cmd * STEP_CYCLES;
            fd    = $fopen("obj_testdata.txt", "r");
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(rest, fd);
                    "T": begin
                        close_test();
                        test_name = '0;
                        code = $fscanf(fd, "%s", test_name);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", a_arg, b_arg, c_arg);
                        cpu_write(a_arg[ADDR_W-1:0], b_arg[15:0], c_arg[1:0]);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a_arg, b_arg);
                        cpu_read(a_arg[ADDR_W-1:0], b_arg[15:0]);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h", a_arg);
                        @(negedge clk);
                        obank = a_arg[0];
                    end
                    "L": begin
                        code = $fscanf(fd, "%h", a_arg);
                        render_line(a_arg[POS_W-1:0]);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", a_arg, b_arg);
                        check_pixel(a_arg[POS_W-1:0], b_arg[PIX_W-1:0]);
                    end
                    default: begin
                        $display("unknown command '%c' in the test data", cmd);
                        test_err++;
                        code = $fgets(rest, fd);
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();
        total_err += dut.u_chk.fail_count;              // Bound checker failures.

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_err);
        if (total_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: obj_testdata.txt
# One command per line, a letter and hex fields. T name, W addr data dsn, R addr expected,
# B obank, L vpos (render and show), P pix_x expected. Entries are X, Y, code, attr words.
T byte_lanes
W 0800 1234 0
R 0800 1234
W 0800 ab00 1
R 0800 ab34
W 0800 00cd 2
R 0800 abcd
T bank_swap
W 0900 1111 0
W 1900 2222 0
R 0900 1111
R 1900 2222
# Object table written into the CPU bank, shown once obank flips
W 0000 0020 0
W 0001 0030 0
W 0003 0011 0
W 0004 0028 0
W 0005 0030 0
W 0007 0022 0
W 0008 0178 0
W 0009 0030 0
W 000b 0033 0
W 000c 0060 0
W 000d 0030 0
W 000f 0000 0
W 0010 00a0 0
W 0011 01f8 0
W 0013 0044 0
W 0014 00c0 0
W 0015 0030 0
W 0017 8055 0
W 0018 00e0 0
W 0019 0030 0
W 001b 0066 0
B 1
R 0900 2222
R 1900 1111
L 030
P 020 11
T vertical
L 03f
P 020 11
L 040
P 020 00
L 02f
P 020 00
L 1f8
P 0a0 44
L 007
P 0a0 44
L 008
P 0a0 00
L 1f7
P 0a0 00
T span_clip
L 030
P 01f 00
P 020 11
P 038 00
P 177 00
P 178 33
P 17f 33
P 180 00
T priority_end
P 02f 11
P 030 22
P 037 22
P 060 00
P 0c0 00
P 0e0 00
T line_clear
L 100
P 020 00
P 030 00
P 178 00

// File: files.f
obj_pkg.sv
obj_ram.sv
obj_scan.sv
obj_line_buf.sv
obj_top.sv
obj_chk.sv
obj_tb.sv

// File: Bender.yml
package:
  name: obj_path

sources:
  - obj_pkg.sv
  - obj_ram.sv
  - obj_scan.sv
  - obj_line_buf.sv
  - obj_top.sv
  - target: test
    files:
      - obj_chk.sv
      - obj_tb.sv
